/* Makefile */
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Ilogic logic/uart_pkg.sv logic/uart_frame_tx.sv \
		logic/uart_frame_rx.sv logic/uart.sv --top-module uart
	verilator --lint-only --timing --assert -f project.f --top-module uart_tb

sim:
	verilator --binary --timing --assert -f project.f --top-module uart_tb -Mdir obj_dir
	./obj_dir/Vuart_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q -F "*** PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/uart_tb.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_tb;
   import uart_pkg::*;

   localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
   localparam int BUSY_CYCLES  = `UART_CMD_BITS * `UART_CLKS_PER_BIT;
   localparam int WATCHDOG_NS  = 40 * BUSY_CYCLES * 10 + 20000;

   logic        clk;
   logic        rst_n;
   cmd_word_t   cmd_in;
   logic        cmd_vld;
   logic        cmd_rdy;
   logic        tx;
   logic        rx;
   logic        read_rdy;
   rx_result_t  read_result;
   logic        loopback_sel;
   logic        inj_line;
   logic        chained;
   int          cycle_cnt = 0;
   int          busy_cnt;
   logic [31:0] rng;
   rx_result_t  exp_q[$];
   rx_result_t  exp_res;

   uart uart_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .cmd_in      (cmd_in),
      .cmd_vld     (cmd_vld),
      .cmd_rdy     (cmd_rdy),
      .tx          (tx),
      .rx          (rx),
      .read_rdy    (read_rdy),
      .read_result (read_result)
   );

   assign rx = loopback_sel ? tx : inj_line;

   always #5 clk = ~clk;

   // ============================================================
   // Reference rules and helpers
   // ============================================================

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int count_ones(input data_byte_t b);
      int n;
      n = 0;
      for (int i = 0; i < 8; i++) begin
         n += int'(b[i]);
      end
      return n;
   endfunction

   // Parity bit that makes the number of ones odd.
   function automatic logic odd_parity_bit(input data_byte_t b);
      return (count_ones(b) % 2 == 0) ? 1'b1 : 1'b0;
   endfunction

   // Bit k of the 22 bits on the line for one command.
   function automatic logic expected_tx_bit(input cmd_word_t word, input int k);
      data_byte_t b;
      int         pos;
      logic       bit_val;
      b   = (k < `UART_FRAME_BITS) ? word[15:8] : word[7:0];
      pos = k % `UART_FRAME_BITS;
      case (pos)
         0:       bit_val = 1'b0;
         9:       bit_val = odd_parity_bit(b);
         10:      bit_val = 1'b1;
         default: bit_val = b[8 - pos];
      endcase
      return bit_val;
   endfunction

   task automatic abort_run;
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic issue_cmd(input cmd_word_t word, input logic hold);
      int waited;
      waited = 0;
      @(negedge clk);
      cmd_in  = word;
      cmd_vld = 1'b1;
      @(posedge clk);
      while (!cmd_rdy) begin
         waited++;
         if (waited > BUSY_CYCLES + 4) begin
            $display("Command %h was never accepted", word);
            abort_run();
         end
         @(posedge clk);
      end
      @(negedge clk);
      if (!hold) begin
         cmd_vld = 1'b0;
      end
   endtask

   // A request inside the busy window, which the transmitter must ignore.
   task automatic busy_pulse(input cmd_word_t word);
      repeat (CLKS_PER_BIT) @(negedge clk);
      cmd_in  = word;
      cmd_vld = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
   endtask

   task automatic wait_idle(input int limit);
      int waited;
      waited = 0;
      while (!cmd_rdy || exp_q.size() != 0) begin
         if (waited >= limit) begin
            $display("Link not idle after %0d cycles, %0d bytes missing", limit, exp_q.size());
            abort_run();
         end
         @(negedge clk);
         waited++;
      end
   endtask

   task automatic inject_frame(input data_byte_t data, input logic flip_par, input logic stop);
      logic [10:0] bits;
      logic        par;
      rx_result_t  res;
      par            = odd_parity_bit(data) ^ flip_par;
      res.data       = data;
      res.parity_err = ((count_ones(data) + int'(par)) % 2 == 0);
      res.stop_err   = !stop;
      exp_q.push_back(res);
      bits = {1'b0, data, par, stop};
      for (int i = 10; i >= 0; i--) begin
         inj_line = bits[i];
         repeat (CLKS_PER_BIT) @(negedge clk);
      end
      inj_line = 1'b1;
      repeat (2 * CLKS_PER_BIT) @(negedge clk);
   endtask

   // ============================================================
   // Checks
   // ============================================================

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_cnt <= 0;
      end else if (cmd_vld && cmd_rdy) begin
         busy_cnt <= 0;
      end else if (!cmd_rdy) begin
         busy_cnt <= busy_cnt + 1;
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   reset_values: assert property (
      @(posedge clk) (!rst_n || $rose(rst_n)) |-> (tx && cmd_rdy && !read_rdy)
   ) else begin
      $display("CHECK FAILED reset: tx %h cmd_rdy %h read_rdy %h",
               $sampled(tx), $sampled(cmd_rdy), $sampled(read_rdy));
      abort_run();
   end

   busy_length: assert property (
      @(posedge clk) disable iff (!rst_n) $rose(cmd_rdy) |-> busy_cnt == BUSY_CYCLES
   ) else begin
      $display("CHECK FAILED cmd_rdy low cycles: got %h expected %h",
               $sampled(busy_cnt), BUSY_CYCLES);
      abort_run();
   end

   busy_bound: assert property (
      @(posedge clk) disable iff (!rst_n) !cmd_rdy |-> busy_cnt < BUSY_CYCLES
   ) else begin
      $display("CHECK FAILED cmd_rdy low cycles: got %h limit %h",
               $sampled(busy_cnt), BUSY_CYCLES);
      abort_run();
   end

   idle_high: assert property (
      @(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx
   ) else begin
      $display("CHECK FAILED tx: got %h expected %h while cmd_rdy is high", $sampled(tx), 1'b1);
      abort_run();
   end

   // Samples each of the 22 bits in the middle of its period.
   initial begin : tx_monitor
      cmd_word_t word;
      int        prev_accept;
      logic      want;
      prev_accept = 0;
      forever begin
         @(posedge clk);
         if (rst_n && cmd_vld && cmd_rdy) begin
            word = cmd_in;
            // Chained commands leave one idle clock, well short of a bit.
            if (chained) begin
               assert (cycle_cnt - prev_accept == BUSY_CYCLES + 1) else begin
                  $display("CHECK FAILED accept gap: got %h expected %h",
                           cycle_cnt - prev_accept, BUSY_CYCLES + 1);
                  abort_run();
               end
            end
            prev_accept = cycle_cnt;
            if (loopback_sel) begin
               exp_q.push_back(rx_result_t'{data: word[15:8], parity_err: 1'b0, stop_err: 1'b0});
               exp_q.push_back(rx_result_t'{data: word[7:0], parity_err: 1'b0, stop_err: 1'b0});
            end
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            for (int k = 0; k < `UART_CMD_BITS; k++) begin
               if (k > 0) begin
                  repeat (CLKS_PER_BIT) @(negedge clk);
               end
               want = expected_tx_bit(word, k);
               assert (tx === want) else begin
                  $display("CHECK FAILED tx bit %0d of %h: got %h expected %h", k, word, tx, want);
                  abort_run();
               end
            end
         end
      end
   end

   always @(posedge clk) begin
      if (rst_n && read_rdy) begin
         assert (exp_q.size() > 0) else begin
            $display("read_rdy strobed with data %h while no byte was expected",
                     read_result.data);
            abort_run();
         end
         if (exp_q.size() > 0) begin
            exp_res = exp_q.pop_front();
            assert (read_result == exp_res) else begin
               $display("CHECK FAILED read_result: got %h expected %h", read_result, exp_res);
               abort_run();
            end
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Watchdog expired before the test sequence completed");
      abort_run();
   end

   // ============================================================
   // Stimulus
   // ============================================================

   initial begin : stimulus
      clk          = 1'b0;
      rst_n        = 1'b1;
      cmd_in       = '0;
      cmd_vld      = 1'b0;
      loopback_sel = 1'b1;
      inj_line     = 1'b1;
      chained      = 1'b0;
      rng          = 32'd53;
      #1 rst_n = 1'b0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      repeat (3) @(negedge clk);

      // Single commands in loopback, every other one with a busy pulse.
      for (int i = 0; i < 12; i++) begin
         rng = xorshift32(rng);
         issue_cmd(rng[15:0], 1'b0);
         if (i % 2 == 1) begin
            busy_pulse(~rng[15:0]);
         end
         wait_idle(2 * BUSY_CYCLES);
         repeat (CLKS_PER_BIT) @(negedge clk);
      end

      // Back-to-back commands with cmd_vld held high.
      for (int i = 0; i < 10; i++) begin
         rng = xorshift32(rng);
         issue_cmd(rng[15:0], i < 9);
         chained = (i < 9);
      end
      wait_idle(2 * BUSY_CYCLES);

      // Injected frames with good and bad parity and stop bits.
      loopback_sel = 1'b0;
      rng = xorshift32(rng);
      inject_frame(rng[7:0], 1'b0, 1'b1);
      inject_frame(rng[15:8], 1'b1, 1'b1);
      inject_frame(rng[23:16], 1'b0, 1'b0);
      inject_frame(rng[31:24], 1'b1, 1'b0);
      inj_line = 1'b0;
      repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
      inj_line = 1'b1;
      repeat (3 * CLKS_PER_BIT) @(negedge clk);
      inject_frame(~rng[7:0], 1'b0, 1'b1);
      wait_idle(2 * BUSY_CYCLES);

      // Transmit and receive at the same time.
      rng = xorshift32(rng);
      fork
         issue_cmd(rng[15:0], 1'b0);
         inject_frame(rng[23:16], 1'b0, 1'b1);
      join
      wait_idle(2 * BUSY_CYCLES);
      repeat (4 * CLKS_PER_BIT) @(negedge clk);

      if (exp_q.size() == 0) begin
         $display("*** PASSED ***");
         $finish;
      end else begin
         $display("%0d received bytes still missing at the end of the run", exp_q.size());
         abort_run();
      end
   end

endmodule

/* logic/uart.sv */
`timescale 1ns/1ps

// ============================================================
// Serial command link
// ============================================================

// Transmit and receive paths share only the clock and reset, so a
// command can go out while a byte is coming in.
module uart (
   input  logic                 clk,
   input  logic                 rst_n,
   input  uart_pkg::cmd_word_t  cmd_in,
   input  logic                 cmd_vld,
   output logic                 cmd_rdy,
   output logic                 tx,
   input  logic                 rx,
   output logic                 read_rdy,
   output uart_pkg::rx_result_t read_result
);

   // Command port to the tx line, two frames per word.
   uart_frame_tx uart_frame_tx_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd_in  (cmd_in),
      .cmd_vld (cmd_vld),
      .cmd_rdy (cmd_rdy),
      .tx      (tx)
   );

   // The rx line to one strobed result per frame.
   uart_frame_rx uart_frame_rx_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .rx          (rx),
      .read_rdy    (read_rdy),
      .read_result (read_result)
   );

endmodule

/* logic/uart_frame_rx.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_frame_rx (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 rx,
   output logic                 read_rdy,
   output uart_pkg::rx_result_t read_result
);
   import uart_pkg::*;

   rx_state_t  state;
   baud_cnt_t  baud_cnt;
   bit_cnt_t   bit_cnt;
   logic       rx_meta;
   logic       rx_sync;
   logic       rx_prev;
   logic       rx_fall;
   logic       half_end;
   logic       bit_end;
   logic       last_bit;
   logic       shift_en;
   data_byte_t data_sr;
   logic       par_acc;

   // ============================================================
   // Input synchronizer and edge detect
   // ============================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   // A start needs a real 1 to 0 transition, so after a stop error the
   // line has to return high before the next frame can begin.
   assign rx_fall = rx_prev && !rx_sync;

   assign half_end = (baud_cnt == baud_cnt_t'(`UART_CLKS_PER_BIT / 2 - 1));
   assign bit_end  = (baud_cnt == baud_cnt_t'(`UART_CLKS_PER_BIT - 1));

   // Data bits take positions 0 to 7, the parity bit position 8.
   assign last_bit = (bit_cnt == bit_cnt_t'(`UART_FRAME_BITS - 3));
   assign shift_en = (state == RX_BITS) && bit_end;

   // ============================================================
   // Frame FSM
   // ============================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= RX_IDLE;
         baud_cnt    <= '0;
         bit_cnt     <= '0;
         read_rdy    <= 1'b0;
         read_result <= '0;
      end else begin
         read_rdy <= 1'b0;
         case (state)
            RX_IDLE: begin
               if (rx_fall) begin
                  state    <= RX_START;
                  baud_cnt <= '0;
               end
            end
            RX_START: begin
               // Mid-bit check of the start bit filters short glitches.
               if (half_end) begin
                  baud_cnt <= '0;
                  bit_cnt  <= '0;
                  if (!rx_sync) begin
                     state <= RX_BITS;
                  end else begin
                     state <= RX_IDLE;
                  end
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            RX_BITS: begin
               if (bit_end) begin
                  baud_cnt <= '0;
                  if (last_bit) begin
                     state <= RX_STOP;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            RX_STOP: begin
               if (bit_end) begin
                  state       <= RX_IDLE;
                  baud_cnt    <= '0;
                  read_rdy    <= 1'b1;
                  read_result <= rx_result_t'{data:       data_sr,
                                              parity_err: !par_acc,
                                              stop_err:   !rx_sync};
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            default: begin
               state <= RX_IDLE;
            end
         endcase
      end
   end

   // ============================================================
   // Data path
   // ============================================================

   // par_acc ends up 1 when data plus parity has an odd count of ones.
   always_ff @(posedge clk) begin
      if (state == RX_START) begin
         par_acc <= 1'b0;
      end else if (shift_en) begin
         par_acc <= par_acc ^ rx_sync;
         if (!last_bit) begin
            data_sr <= {data_sr[6:0], rx_sync};
         end
      end
   end

   // ============================================================
   // Assertions
   // ============================================================

   a_strobe_single: assert property (
      @(posedge clk) disable iff (!rst_n)
      read_rdy |=> !read_rdy
   ) else $error("read_rdy high for two cycles in a row");

   a_strobe_from_stop: assert property (
      @(posedge clk) disable iff (!rst_n)
      read_rdy |-> ($past(state) == RX_STOP) && (state == RX_IDLE)
   ) else $error("read_rdy raised without leaving RX_STOP");

endmodule

/* logic/uart_frame_tx.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_frame_tx (
   input  logic                clk,
   input  logic                rst_n,
   input  uart_pkg::cmd_word_t cmd_in,
   input  logic                cmd_vld,
   output logic                cmd_rdy,
   output logic                tx
);
   import uart_pkg::*;

   tx_state_t                 state;
   baud_cnt_t                 baud_cnt;
   bit_cnt_t                  bit_cnt;
   logic [`UART_CMD_BITS-1:0] frame_q;
   logic [`UART_CMD_BITS-1:0] frame_d;
   data_byte_t                hi_byte;
   data_byte_t                lo_byte;
   logic                      hi_par;
   logic                      lo_par;
   logic                      accept;
   logic                      bit_end;
   logic                      last_bit;

   // ============================================================
   // Frame assembly
   // ============================================================

   assign hi_byte = cmd_in[15:8];
   assign lo_byte = cmd_in[7:0];

   // The parity bit makes the count of ones odd.
   assign hi_par = ~^hi_byte;
   assign lo_par = ~^lo_byte;

   // Leftmost bit goes out first.
   assign frame_d = {1'b0, hi_byte, hi_par, 1'b1,
                     1'b0, lo_byte, lo_par, 1'b1};

   assign accept   = cmd_vld && cmd_rdy;
   assign bit_end  = (baud_cnt == baud_cnt_t'(`UART_CLKS_PER_BIT - 1));
   assign last_bit = (bit_cnt == bit_cnt_t'(`UART_CMD_BITS - 1));

   // ============================================================
   // Control
   // ============================================================

   // The start bit is driven at the acceptance edge, so every bit
   // including the last stop bit lasts exactly one period.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= TX_IDLE;
         cmd_rdy  <= 1'b1;
         tx       <= 1'b1;
         baud_cnt <= '0;
         bit_cnt  <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               if (accept) begin
                  state    <= TX_SEND;
                  cmd_rdy  <= 1'b0;
                  tx       <= frame_d[`UART_CMD_BITS-1];
                  baud_cnt <= '0;
                  bit_cnt  <= '0;
               end
            end
            TX_SEND: begin
               if (bit_end) begin
                  baud_cnt <= '0;
                  if (last_bit) begin
                     state   <= TX_IDLE;
                     cmd_rdy <= 1'b1;
                     tx      <= 1'b1;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                     tx      <= frame_q[`UART_CMD_BITS-1];
                  end
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            default: begin
               state <= TX_IDLE;
            end
         endcase
      end
   end

   // Bit 21 of the shift register is the next bit to go out.
   always_ff @(posedge clk) begin
      if (accept) begin
         frame_q <= {frame_d[`UART_CMD_BITS-2:0], 1'b1};
      end else if (state == TX_SEND && bit_end) begin
         frame_q <= {frame_q[`UART_CMD_BITS-2:0], 1'b1};
      end
   end

   // ============================================================
   // Assertions
   // ============================================================

   a_busy_not_ready: assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == TX_SEND) |-> !cmd_rdy
   ) else $error("cmd_rdy high while a command is being sent");

   a_bit_cnt_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      bit_cnt <= bit_cnt_t'(`UART_CMD_BITS - 1)
   ) else $error("bit_cnt past the last bit: %0d", bit_cnt);

endmodule

/* logic/uart_macros.svh */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// ============================================================
// Serial link timing and framing
// ============================================================

// Clock cycles per serial bit. Any value of 4 or more works.
`define UART_CLKS_PER_BIT 8

// Start bit, eight data bits, odd parity and stop bit.
`define UART_FRAME_BITS 11

// A command word goes out as two frames back to back.
`define UART_CMD_BITS 22

`endif

/* logic/uart_pkg.sv */
`include "uart_macros.svh"

package uart_pkg;

   // ============================================================
   // Data widths
   // ============================================================

   // Command word. The high byte goes out first.
   typedef logic [15:0] cmd_word_t;

   typedef logic [7:0] data_byte_t;

   // Bit position within a command, 0 to 21.
   typedef logic [4:0] bit_cnt_t;

   // Clock cycle within one bit period.
   typedef logic [$clog2(`UART_CLKS_PER_BIT + 1)-1:0] baud_cnt_t;

   // ============================================================
   // Receive report
   // ============================================================

   // Parity error means data plus parity held an even number of ones.
   typedef struct packed {
      data_byte_t data;
      logic       parity_err;
      logic       stop_err;
   } rx_result_t;

   // ============================================================
   // State machines
   // ============================================================

   typedef enum logic {
      TX_IDLE,
      TX_SEND
   } tx_state_t;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_BITS,
      RX_STOP
   } rx_state_t;

endpackage

/* project.f */
+incdir+logic
logic/uart_pkg.sv
logic/uart_frame_tx.sv
logic/uart_frame_rx.sv
logic/uart.sv
bench/uart_tb.sv
